/* rtl/rgb565_colors.svh */
`ifndef RGB565_COLORS_SVH
`define RGB565_COLORS_SVH

// RGB565 packing. Red in [15:11], green in [10:5], blue in [4:0].
// Needs pixel_t declared ahead of the include point.

localparam pixel_t COLOR_BLACK  = 16'h0000; // All channels off.
localparam pixel_t COLOR_GREEN  = 16'h07E0; // Full green only.
localparam pixel_t COLOR_YELLOW = 16'hFFE0; // Full red plus full green.

// Pink is 255/192/203 in 8-bit terms.
// Truncated to 31/48/25 per channel.
localparam pixel_t COLOR_PINK   = 16'hFE19;

`endif

/* rtl/draw_pkg.sv */
package draw_pkg;

  //////////////////////////////
  // Widths with a meaning.
  //////////////////////////////
  typedef logic [23:0] addr_t;   // Bank(2) + row(13) + column(9).
  typedef logic [15:0] pixel_t;  // One RGB565 pixel.
  typedef logic [11:0] coord_t;  // Row, column or pixel count.
  typedef logic [6:0]  sample_t; // Sine sample, 0 to 127.

  // Named colours, built on pixel_t.
  `include "rgb565_colors.svh"

  // Points in one sine period.
  localparam int SINE_LEN = 120;

  // Host opcodes. Anything else gets dropped.
  typedef enum logic [3:0] {
    CMD_CLEAR = 4'd0,
    CMD_IMAGE = 4'd1,
    CMD_SINE  = 4'd2
  } draw_cmd_e;

  typedef enum logic {
    RUN_LINE = 1'b0, // Fixed step between pixels.
    RUN_SINE = 1'b1  // Row step plus sine offset.
  } run_kind_e;

  // One straight run of pixels, 78 bits.
  typedef struct packed {
    run_kind_e kind;
    addr_t     start; // Address of first pixel.
    addr_t     step;  // Added after each pixel.
    coord_t    count; // Pixels in the run, at least 1.
    pixel_t    color;
    logic      last;  // Final run of the command.
  } run_t;

  // One pixel write, 41 bits.
  typedef struct packed {
    addr_t  addr;
    pixel_t data;
    logic   last; // Final pixel of the command.
  } pix_t;

endpackage

/* rtl/sine_rom.sv */
`timescale 1ns/1ps

module sine_rom (
  input  logic              clk,
  input  logic [6:0]        idx,
  output draw_pkg::sample_t sample
);
  import draw_pkg::*;

  localparam real PI = 3.14159265358979323846;

  sample_t rom [SINE_LEN]; // One full period.

  //////////////////////////////
  // Table contents.
  //////////////////////////////
  // S(k) = round(63.5 + 63.5*sin(2*pi*k/120)).
  initial begin
    real value;
    for (int k = 0; k < SINE_LEN; k++) begin
      value  = 63.5 + 63.5 * $sin(2.0 * PI * k / SINE_LEN);
      rom[k] = sample_t'($rtoi(value + 0.5)); // Never negative, so truncation rounds.
    end
  end

  // Registered read, one cycle of latency.
  // Caller keeps idx below 120.
  always_ff @(posedge clk) begin
    sample <= rom[idx];
  end

endmodule

/* rtl/draw_cmd_decode.sv */
`timescale 1ns/1ps

module draw_cmd_decode #(
  parameter int WIDTH  = 480,
  parameter int HEIGHT = 800,
  parameter int MARGIN = 10
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_valid,
  input  draw_pkg::draw_cmd_e cmd,
  output draw_pkg::run_t      run,
  output logic                run_valid,
  input  logic                run_take,
  output logic                busy,
  input  logic                draw_done
);
  import draw_pkg::*;

  //////////////////////////////
  // Geometry of the runs.
  //////////////////////////////
  localparam addr_t  TOP_LEFT  = addr_t'(MARGIN * WIDTH + MARGIN);
  localparam addr_t  BOT_LEFT  = addr_t'((HEIGHT - 1 - MARGIN) * WIDTH + MARGIN);
  localparam addr_t  TOP_RIGHT = addr_t'(MARGIN * WIDTH + WIDTH - 1 - MARGIN);
  localparam addr_t  TOP_MID   = addr_t'(MARGIN * WIDTH + WIDTH / 2);
  localparam addr_t  ROW_STEP  = addr_t'(WIDTH);          // One row down.
  localparam coord_t HSPAN     = coord_t'(WIDTH - 2 * MARGIN);
  localparam coord_t VSPAN     = coord_t'(HEIGHT - 2 * MARGIN);
  localparam coord_t ROW_LEN   = coord_t'(WIDTH);
  localparam coord_t LAST_ROW  = coord_t'(HEIGHT - 1);

  logic      busy_r;    // Command in flight.
  logic      all_taken; // Last run already handed out.
  draw_cmd_e op;        // Latched opcode.
  coord_t    run_idx;   // Index of the run on offer.
  addr_t     row_base;  // Start of the current row for clear.
  logic      accept;

  // Drops at once with the done pulse.
  assign busy      = busy_r & ~draw_done;
  assign run_valid = busy_r & ~all_taken;
  assign accept    = cmd_valid & ~busy & (cmd inside {CMD_CLEAR, CMD_IMAGE, CMD_SINE});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_r    <= 1'b0;
      all_taken <= 1'b0;
      op        <= CMD_CLEAR;
      run_idx   <= '0;
      row_base  <= '0;
    end else begin
      if (draw_done)
        busy_r <= 1'b0;
      if (accept) begin // Wins over the done clear.
        busy_r    <= 1'b1;
        all_taken <= 1'b0;
        op        <= cmd;
        run_idx   <= '0;
        row_base  <= '0;
      end else if (run_take) begin
        run_idx  <= run_idx + coord_t'(1);
        row_base <= row_base + ROW_STEP; // Only clear looks at it.
        if (run.last)
          all_taken <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Run descriptor on offer.
  //////////////////////////////
  always_comb begin
    run      = '0;
    run.kind = RUN_LINE;
    run.step = addr_t'(1);
    case (op)
      CMD_CLEAR: begin // One run per row in address order.
        run.start = row_base;
        run.count = ROW_LEN;
        run.color = COLOR_BLACK;
        run.last  = (run_idx == LAST_ROW);
      end
      CMD_IMAGE: begin
        run.step  = ROW_STEP; // Vertical unless overridden.
        run.count = VSPAN;
        run.color = COLOR_GREEN;
        case (run_idx)
          12'd0: begin // Top edge.
            run.start = TOP_LEFT;
            run.step  = addr_t'(1);
            run.count = HSPAN;
          end
          12'd1: begin // Bottom edge.
            run.start = BOT_LEFT;
            run.step  = addr_t'(1);
            run.count = HSPAN;
          end
          12'd2: run.start = TOP_LEFT;  // Left edge.
          12'd3: run.start = TOP_RIGHT; // Right edge.
          default: begin
            // Centre column drawn last so it sits on top.
            run.start = TOP_MID;
            run.color = COLOR_YELLOW;
            run.last  = 1'b1;
          end
        endcase
      end
      CMD_SINE: begin
        run.kind  = RUN_SINE;
        run.start = TOP_LEFT; // Row base of the first sample.
        run.step  = ROW_STEP;
        run.count = VSPAN;
        run.color = COLOR_PINK;
        run.last  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* rtl/run_walker.sv */
`timescale 1ns/1ps

module run_walker #(
  parameter int AMP_SHIFT = 0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  draw_pkg::run_t    run,
  input  logic              run_valid,
  output logic              run_take,
  output logic [6:0]        sine_idx,
  input  draw_pkg::sample_t sine_sample,
  input  logic              port_ready,
  output draw_pkg::pix_t    pix,
  output logic              pix_valid
);
  import draw_pkg::*;

  localparam logic [6:0] SINE_LAST = 7'(SINE_LEN - 1);

  typedef enum logic [1:0] {
    IDLE,  // Waiting for a run.
    LOAD,  // Set up the next pixel.
    FETCH, // Sine sample arriving.
    EMIT   // Pixel offered to the port.
  } walk_state_e;

  walk_state_e state;
  run_kind_e   kind;
  coord_t      remain;   // Pixels left in the run.
  logic        last_run;
  logic [6:0]  tbl_idx;  // Sine index for the current row.
  addr_t       cur_addr; // Line address or sine row base.
  addr_t       step;
  pixel_t      color;
  addr_t       pix_addr;
  addr_t       offset;   // Scaled sine sample.

  assign run_take  = (state == IDLE) & run_valid;
  assign pix_valid = (state == EMIT) & port_ready;
  assign sine_idx  = tbl_idx;
  assign offset    = addr_t'(sine_sample >> AMP_SHIFT);

  always_comb begin
    pix.addr = pix_addr;
    pix.data = color;
    pix.last = last_run & (remain == coord_t'(1)); // End of the command.
  end

  //////////////////////////////
  // Control.
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      kind     <= RUN_LINE;
      remain   <= '0;
      last_run <= 1'b0;
      tbl_idx  <= '0;
    end else begin
      case (state)
        IDLE:
          if (run_valid) begin
            kind     <= run.kind;
            remain   <= run.count;
            last_run <= run.last;
            tbl_idx  <= '0; // Trace restarts at k = 0.
            state    <= LOAD;
          end
        LOAD:
          state <= (kind == RUN_SINE) ? FETCH : EMIT;
        FETCH:
          state <= EMIT;
        EMIT:
          if (port_ready) begin
            remain  <= remain - coord_t'(1);
            tbl_idx <= (tbl_idx == SINE_LAST) ? 7'd0 : tbl_idx + 7'd1; // Wrap at 120.
            state   <= (remain == coord_t'(1)) ? IDLE : LOAD;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Address datapath.
  //////////////////////////////
  always_ff @(posedge clk) begin
    case (state)
      IDLE:
        if (run_valid) begin
          cur_addr <= run.start;
          step     <= run.step;
          color    <= run.color;
        end
      LOAD:
        if (kind == RUN_LINE)
          pix_addr <= cur_addr;
      FETCH:
        pix_addr <= cur_addr + offset; // Row base plus column offset.
      EMIT:
        if (port_ready)
          cur_addr <= cur_addr + step; // Next pixel, or next row for sine.
      default: ;
    endcase
  end

endmodule

/* rtl/fb_write_port.sv */
`timescale 1ns/1ps

module fb_write_port (
  input  logic             clk,
  input  logic             rst_n,
  input  draw_pkg::pix_t   pix,
  input  logic             pix_valid,
  output logic             port_ready,
  output logic             wr_req,
  output draw_pkg::addr_t  wr_addr,
  output draw_pkg::pixel_t wr_data,
  input  logic             wr_done,
  output logic             draw_done
);
  import draw_pkg::*;

  typedef enum logic [1:0] {
    P_IDLE, // Ready for a pixel.
    P_REQ,  // Request held until done.
    P_GAP   // Request low, one cycle minimum.
  } port_state_e;

  port_state_e state;
  logic        last_q;    // Pixel in flight ends the command.
  logic        done_pend; // Last write just finished.

  assign port_ready = (state == P_IDLE);
  assign wr_req     = (state == P_REQ);

  //////////////////////////////
  // Handshake control.
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= P_IDLE;
      last_q    <= 1'b0;
      done_pend <= 1'b0;
      draw_done <= 1'b0;
    end else begin
      done_pend <= (state == P_REQ) & wr_done & last_q;
      draw_done <= done_pend; // Two cycles after the last wr_done.
      case (state)
        P_IDLE:
          if (pix_valid) begin
            last_q <= pix.last;
            state  <= P_REQ;
          end
        P_REQ:
          if (wr_done)
            state <= P_GAP;
        P_GAP:
          state <= P_IDLE;
        default:
          state <= P_IDLE;
      endcase
    end
  end

  // Address and data stay put for the whole request.
  always_ff @(posedge clk) begin
    if (port_ready && pix_valid) begin
      wr_addr <= pix.addr;
      wr_data <= pix.data;
    end
  end

endmodule

/* rtl/draw_core.sv */
`timescale 1ns/1ps

module draw_core #(
  parameter int WIDTH     = 480,
  parameter int HEIGHT    = 800,
  parameter int MARGIN    = 10,
  parameter int AMP_SHIFT = 0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_valid,
  input  draw_pkg::draw_cmd_e cmd,
  output logic                busy,
  output logic                draw_done,
  output logic                wr_req,
  output draw_pkg::addr_t     wr_addr,
  output draw_pkg::pixel_t    wr_data,
  input  logic                wr_done
);
  import draw_pkg::*;

  //////////////////////////////
  // Internal links.
  //////////////////////////////
  run_t       run;
  logic       run_valid;
  logic       run_take;
  logic [6:0] sine_idx;
  sample_t    sine_sample;
  pix_t       pix;
  logic       pix_valid;
  logic       port_ready;

  // Decode. Command into runs.
  draw_cmd_decode #(
    .WIDTH (WIDTH),
    .HEIGHT(HEIGHT),
    .MARGIN(MARGIN)
  ) u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd      (cmd),
    .run      (run),
    .run_valid(run_valid),
    .run_take (run_take),
    .busy     (busy),
    .draw_done(draw_done)
  );

  // Execute. Runs into pixels.
  run_walker #(
    .AMP_SHIFT(AMP_SHIFT)
  ) u_walker (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .run_valid  (run_valid),
    .run_take   (run_take),
    .sine_idx   (sine_idx),
    .sine_sample(sine_sample),
    .port_ready (port_ready),
    .pix        (pix),
    .pix_valid  (pix_valid)
  );

  sine_rom u_sine (
    .clk   (clk),
    .idx   (sine_idx),
    .sample(sine_sample)
  );

  // Result. Memory writes and completion.
  fb_write_port u_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix       (pix),
    .pix_valid (pix_valid),
    .port_ready(port_ready),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_done   (wr_done),
    .draw_done (draw_done)
  );

endmodule

/* sim/draw_core_chk.sv */
`timescale 1ns/1ps

module draw_core_chk (
  input logic             clk,
  input logic             rst_n,
  input logic             busy,
  input logic             draw_done,
  input logic             wr_req,
  input draw_pkg::addr_t  wr_addr,
  input draw_pkg::pixel_t wr_data,
  input logic             wr_done
);

  //////////////////////////////
  // Memory handshake.
  //////////////////////////////
  hold_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_done |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else $error("write request dropped or changed before done");

  req_low_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    wr_done |=> !wr_req)
    else $error("write request still high in the cycle after done");

  //////////////////////////////
  // Completion.
  //////////////////////////////
  done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    draw_done |=> !draw_done)
    else $error("draw done lasted more than one cycle");

  busy_drops_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    draw_done |-> !busy && $past(busy))
    else $error("busy did not fall together with draw done");

  busy_fall_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> draw_done)
    else $error("busy fell without a draw done pulse");

endmodule

bind draw_core draw_core_chk u_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .busy     (busy),
  .draw_done(draw_done),
  .wr_req   (wr_req),
  .wr_addr  (wr_addr),
  .wr_data  (wr_data),
  .wr_done  (wr_done)
);

/* sim/tb_draw_core.sv */
`timescale 1ns/1ps

module tb_draw_core;
  import draw_pkg::*;

  localparam int  W       = 32;
  localparam int  H       = 24;
  localparam int  M       = 2;
  localparam int  SHIFT   = 3;
  localparam int  FB_SIZE = W * H;
  localparam int  N_CLEAR = W * H;
  localparam int  N_IMAGE = 2 * (W - 2 * M) + 3 * (H - 2 * M);
  localparam int  N_SINE  = H - 2 * M;
  localparam int  N_ENT   = 6;
  localparam int  LIMIT   = (N_CLEAR + 2 * N_IMAGE + 2 * N_SINE) * 8 + 2000; // Cycles.
  localparam real PI      = 3.14159265358979;

  // One command table row.
  typedef struct packed {
    logic [3:0]  op;
    logic [15:0] writes;  // Expected memory writes.
    logic        poke;    // Second strobe sent while busy.
    logic [3:0]  poke_op;
  } entry_t;

  logic      clk;
  logic      rst_n;
  logic      cmd_valid;
  draw_cmd_e cmd;
  logic      busy;
  logic      draw_done;
  logic      wr_req;
  addr_t     wr_addr;
  pixel_t    wr_data;
  logic      wr_done = 1'b0;

  pixel_t frame [FB_SIZE];     // Memory contents.
  pixel_t ref_frame [FB_SIZE]; // Expected contents.
  int     sine_ref [120];
  entry_t cmd_tbl [N_ENT];
  int     write_count = 0;
  int     done_count = 0;
  int     cycle_count = 0;
  int     mem_wait = 0;
  logic   mem_busy = 1'b0;
  integer seed = 32'he3ca;

  draw_core #(.WIDTH(W), .HEIGHT(H), .MARGIN(M), .AMP_SHIFT(SHIFT)) UUT (
    .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd), .busy(busy),
    .draw_done(draw_done), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
    .wr_done(wr_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT)
      fail_stop($sformatf("timeout, no progress after %0d cycles", cycle_count));
  end

  always @(posedge clk)
    if (draw_done)
      done_count <= done_count + 1; // Pulses seen so far.

  //////////////////////////////
  // Memory model.
  //////////////////////////////
  initial begin
    for (int a = 0; a < FB_SIZE; a++)
      frame[a] = pixel_t'(a) ^ 16'hA5A5; // Fill pattern unique per address.
    forever begin
      @(posedge clk);
      #1;
      if (!rst_n || wr_done) begin // Done is a single-cycle pulse.
        wr_done  = 1'b0;
        mem_busy = 1'b0;
      end else if (wr_req) begin
        if (!mem_busy) begin
          mem_busy = 1'b1;
          mem_wait = $unsigned($random(seed)) % 4; // 0 to 3 cycles.
        end
        if (mem_wait == 0) begin
          assert (int'(wr_addr) < FB_SIZE) else
            fail_stop($sformatf("mismatch at %0t: write address %0d lies outside the frame",
                                $time, wr_addr));
          frame[int'(wr_addr)] = wr_data;
          write_count++;
          wr_done = 1'b1;
        end else begin
          mem_wait--;
        end
      end
    end
  end

  //////////////////////////////
  // Reference frame model.
  //////////////////////////////
  task automatic ref_line(input int row, input int col, input int d_row, input int d_col,
                          input int n, input pixel_t color);
    for (int i = 0; i < n; i++)
      ref_frame[(row + i * d_row) * W + col + i * d_col] = color;
  endtask

  task automatic ref_apply(input logic [3:0] op);
    case (op)
      4'd0: ref_line(0, 0, 0, 1, FB_SIZE, COLOR_BLACK); // Whole frame in order.
      4'd1: begin // Later runs overwrite earlier ones.
        ref_line(M, M, 0, 1, W - 2 * M, COLOR_GREEN);
        ref_line(H - 1 - M, M, 0, 1, W - 2 * M, COLOR_GREEN);
        ref_line(M, M, 1, 0, H - 2 * M, COLOR_GREEN);
        ref_line(M, W - 1 - M, 1, 0, H - 2 * M, COLOR_GREEN);
        ref_line(M, W / 2, 1, 0, H - 2 * M, COLOR_YELLOW);
      end
      4'd2:
        for (int r = M; r <= H - 1 - M; r++)
          ref_frame[r * W + M + (sine_ref[(r - M) % 120] >> SHIFT)] = COLOR_PINK;
      default: ;
    endcase
  endtask

  task automatic compare_frame();
    for (int a = 0; a < FB_SIZE; a++)
      assert (frame[a] === ref_frame[a]) else
        fail_stop($sformatf("mismatch at %0t: pixel %0d is %h, expected %h",
                            $time, a, frame[a], ref_frame[a]));
  endtask

  //////////////////////////////
  // Stimulus.
  //////////////////////////////
  task automatic strobe(input logic [3:0] op);
    @(posedge clk);
    #1;
    cmd_valid = 1'b1;
    cmd       = draw_cmd_e'(op);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic run_entry(input entry_t ent);
    int   writes0;
    int   done0;
    logic known;
    writes0 = write_count;
    done0   = done_count;
    known   = ent.op inside {4'd0, 4'd1, 4'd2};
    strobe(ent.op);
    if (known) begin
      if (ent.poke) begin
        repeat (3) @(posedge clk);
        #2;
        assert (busy) else fail_stop("busy is low while a draw is running");
        strobe(ent.poke_op); // Lands while busy.
      end
      while (done_count == done0) begin
        @(posedge clk);
        #2;
      end
    end
    repeat (50) @(posedge clk); // Quiet window after the command.
    #2;
    ref_apply(ent.op);
    assert (write_count == writes0 + int'(ent.writes)) else
      fail_stop($sformatf("mismatch at %0t: op %0d made %0d writes, expected %0d",
                          $time, ent.op, write_count - writes0, ent.writes));
    assert (done_count == done0 + (known ? 1 : 0)) else
      fail_stop($sformatf("mismatch at %0t: op %0d gave %0d done pulses",
                          $time, ent.op, done_count - done0));
    assert (!busy && !wr_req) else fail_stop("engine not idle after the command");
    compare_frame();
  endtask

  initial begin
    real v;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = CMD_CLEAR;
    for (int k = 0; k < 120; k++) begin
      v           = 63.5 + 63.5 * $sin(2.0 * PI * k / 120.0);
      sine_ref[k] = int'($floor(v + 0.5)); // Nearest integer.
    end
    for (int a = 0; a < FB_SIZE; a++)
      ref_frame[a] = pixel_t'(a) ^ 16'hA5A5;
    cmd_tbl[0] = '{op: 4'd0, writes: 16'(N_CLEAR), poke: 1'b0, poke_op: 4'd0};
    cmd_tbl[1] = '{op: 4'd1, writes: 16'(N_IMAGE), poke: 1'b1, poke_op: 4'd0};
    cmd_tbl[2] = '{op: 4'd2, writes: 16'(N_SINE), poke: 1'b1, poke_op: 4'd1};
    cmd_tbl[3] = '{op: 4'd5, writes: 16'd0, poke: 1'b0, poke_op: 4'd0}; // Unknown.
    cmd_tbl[4] = '{op: 4'd2, writes: 16'(N_SINE), poke: 1'b1, poke_op: 4'd2};
    cmd_tbl[5] = '{op: 4'd1, writes: 16'(N_IMAGE), poke: 1'b0, poke_op: 4'd0};
    repeat (16) @(posedge clk);
    #1;
    assert (!wr_req && !draw_done && !busy && !UUT.run_valid && !UUT.run_take
            && !UUT.pix_valid) else fail_stop("outputs are not idle during reset");
    rst_n = 1'b1;
    for (int e = 0; e < N_ENT; e++)
      run_entry(cmd_tbl[e]);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+rtl
rtl/draw_pkg.sv
rtl/sine_rom.sv
rtl/draw_cmd_decode.sv
rtl/run_walker.sv
rtl/fb_write_port.sv
rtl/draw_core.sv
sim/draw_core_chk.sv
sim/tb_draw_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the draw_core testbench with Verilator. The result comes from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_draw_core \
  -f flist.f -Mdir obj_dir > sim.log 2>&1 \
  && ./obj_dir/Vtb_draw_core >> sim.log 2>&1 \
  || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
